// File: source/desc_config.svh
`ifndef DESC_CONFIG_SVH
`define DESC_CONFIG_SVH

// ----------------------------------------------------------------------
// Lite bus widths
// ----------------------------------------------------------------------
`define DESC_ADDR_WIDTH 32
`define DESC_DATA_WIDTH 32

// ----------------------------------------------------------------------
// Register map
// ----------------------------------------------------------------------
`define NIC_BASE_ADDR          32'h6000_0000 // Wireless chip window
`define NIC_ISR_OFFSET         32'h0000_0080
`define NIC_ISR_RAC_OFFSET     32'h0000_00c0 // Read-to-clear view of the ISR

`define PCIE_BASE_ADDR         32'h5000_0000 // PCIe controller window
`define PCIE_INT_DECODE_OFFSET 32'h0000_0138
`define PCIE_INT_FIFO_OFFSET   32'h0000_0158

// ----------------------------------------------------------------------
// ISR bits
// ----------------------------------------------------------------------
`define ISR_HP_RXOK            32'h0000_0001 // High priority receive done
`define ISR_RXINTM             32'h8000_0000 // Rx mitigation timer
`define ISR_RXMINTR            32'h0100_0000 // Rx mitigation threshold

// Only this exact value lets the handler swallow the interrupt
`define ISR_CLEAR_ALL_VALUE    (`ISR_HP_RXOK | `ISR_RXINTM | `ISR_RXMINTR)

// ----------------------------------------------------------------------
// PCIe interrupt clear values
// ----------------------------------------------------------------------
`define PCIE_INT_DECODE_CLEAR  32'h0001_0000
`define PCIE_INT_FIFO_CLEAR    32'hffff_ffff

`endif

// File: source/desc_pkg.sv
`include "desc_config.svh"

package desc_pkg;

    // One bus address
    typedef logic [`DESC_ADDR_WIDTH-1:0] addr_t;

    // One register word
    typedef logic [`DESC_DATA_WIDTH-1:0] data_t;

    // Access kind on the lite bus
    typedef enum logic {
        LITE_READ  = 1'b0,
        LITE_WRITE = 1'b1
    } lite_op_t;

endpackage

// File: source/lite_arbiter.sv
`timescale 1ns/10ps

module lite_arbiter (
    input  logic               clk,
    input  logic               reset_n,
    // Interrupt handler side
    input  logic               irq_req,
    input  desc_pkg::lite_op_t irq_op,
    input  desc_pkg::addr_t    irq_addr,
    input  desc_pkg::data_t    irq_wdata,
    output logic               irq_done,
    // Forwarder side that only writes
    input  logic               tx_req,
    input  desc_pkg::addr_t    tx_addr,
    input  desc_pkg::data_t    tx_wdata,
    output logic               tx_done,
    // Read data shared by both requesters
    output desc_pkg::data_t    rdata,
    // Lite bus
    output logic               lite_start,
    output desc_pkg::lite_op_t lite_op,
    output desc_pkg::addr_t    lite_addr,
    output desc_pkg::data_t    lite_wdata,
    input  logic               lite_done,
    input  desc_pkg::data_t    lite_rdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,
        ARB_RELEASE
    } arb_state_t;

    arb_state_t state;
    logic       owner_irq;  // Set when the handler owns the bus
    logic       grant_irq;
    logic       grant_tx;
    logic       finish;

    // Interrupt side always wins
    assign grant_irq = (state == ARB_IDLE) && irq_req;
    assign grant_tx  = (state == ARB_IDLE) && !irq_req && tx_req;
    assign finish    = (state == ARB_BUSY) && lite_done;

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= ARB_IDLE;
            owner_irq  <= 1'b0;
            lite_start <= 1'b0;
            irq_done   <= 1'b0;
            tx_done    <= 1'b0;
        end else begin
            lite_start <= grant_irq || grant_tx;  // One cycle pulse
            irq_done   <= finish && owner_irq;
            tx_done    <= finish && !owner_irq;
            case (state)
                ARB_IDLE: begin
                    if (grant_irq || grant_tx) begin
                        owner_irq <= grant_irq;
                        state     <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (lite_done) begin
                        state <= ARB_RELEASE;
                    end
                end
                // Requester drops its line during this cycle
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Bus payload and read data
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (grant_irq) begin
            lite_op    <= irq_op;
            lite_addr  <= irq_addr;
            lite_wdata <= irq_wdata;
        end else if (grant_tx) begin
            lite_op    <= desc_pkg::LITE_WRITE;
            lite_addr  <= tx_addr;
            lite_wdata <= tx_wdata;
        end
        if (finish) begin
            rdata <= lite_rdata;
        end
    end

    // A new start only after the bus reported the previous access done
    a_one_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
        lite_start |=> (!lite_start until_with lite_done));

    // Done goes back only to a requester still holding its line
    a_done_to_owner: assert property (@(posedge clk) disable iff (!reset_n)
        (irq_done || tx_done) |-> (irq_done ? irq_req : tx_req));

endmodule

// File: source/txcmd_forwarder.sv
`timescale 1ns/10ps

module txcmd_forwarder (
    input  logic            clk,
    input  logic            reset_n,
    // Show-ahead command FIFO
    input  logic            fifo_empty,
    input  desc_pkg::data_t fifo_dread,
    output logic            fifo_rd_en,
    // Requester port toward the arbiter
    output logic            req,
    output desc_pkg::addr_t addr,
    output desc_pkg::data_t wdata,
    input  logic            done
);

    typedef enum logic [1:0] {
        S_ADDR,
        S_DATA,
        S_REQ,
        S_WAIT
    } fwd_state_t;

    fwd_state_t state;
    logic       take_addr;
    logic       take_data;

    assign take_addr = (state == S_ADDR) && !fifo_empty;
    // Head still shows the address word while its pop is in flight
    assign take_data = (state == S_DATA) && !fifo_rd_en && !fifo_empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= S_ADDR;
            fifo_rd_en <= 1'b0;
            req        <= 1'b0;
        end else begin
            fifo_rd_en <= take_addr || take_data;
            case (state)
                S_ADDR: begin
                    if (take_addr) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (take_data) begin
                        req   <= 1'b1;
                        state <= S_REQ;
                    end
                end
                S_REQ: state <= S_WAIT;  // Data pop completes here
                default: begin
                    if (done) begin
                        req   <= 1'b0;
                        state <= S_ADDR;
                    end
                end
            endcase
        end
    end

    // Words captured as they are popped
    always_ff @(posedge clk) begin
        if (take_addr) begin
            addr <= fifo_dread;
        end
        if (take_data) begin
            wdata <= fifo_dread;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        fifo_rd_en |-> !fifo_empty);

endmodule

// File: source/irq_handler.sv
`timescale 1ns/10ps
`include "desc_config.svh"

module irq_handler (
    input  logic               clk,
    input  logic               reset_n,
    // Interrupt lines
    input  logic               irq_in,
    output logic               irq_out,
    // Requester port toward the arbiter
    output logic               req,
    output desc_pkg::lite_op_t op,
    output desc_pkg::addr_t    addr,
    output desc_pkg::data_t    wdata,
    input  logic               done,
    input  desc_pkg::data_t    rdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_ISR,
        S_RD_RAC,
        S_WR_DECODE,
        S_WR_FIFO,
        S_WR_HP,
        S_PASS
    } irq_state_t;

    irq_state_t state;
    irq_state_t seq_next;  // Where to go once the current access is done
    logic       clear_all;
    logic       hp_set;

    assign clear_all = (rdata == `ISR_CLEAR_ALL_VALUE);
    assign hp_set    = (rdata & `ISR_HP_RXOK) != '0;

    // ----------------------------------------------------------------------
    // Sequence decisions
    // ----------------------------------------------------------------------
    always_comb begin
        case (state)
            S_RD_ISR: begin
                if (clear_all) begin
                    seq_next = S_RD_RAC;
                end else if (hp_set) begin
                    seq_next = S_WR_HP;
                end else begin
                    seq_next = irq_in ? S_PASS : S_IDLE;
                end
            end
            S_RD_RAC:    seq_next = S_WR_DECODE;
            S_WR_DECODE: seq_next = S_WR_FIFO;
            S_WR_FIFO:   seq_next = S_IDLE;
            S_WR_HP:     seq_next = irq_in ? S_PASS : S_IDLE;
            default:     seq_next = state;
        endcase
    end

    // Payload follows the state and stays stable while req is up
    always_comb begin
        op    = desc_pkg::LITE_WRITE;
        addr  = `NIC_BASE_ADDR + `NIC_ISR_OFFSET;
        wdata = `ISR_HP_RXOK;
        case (state)
            S_RD_ISR: op = desc_pkg::LITE_READ;
            S_RD_RAC: begin
                op   = desc_pkg::LITE_READ;
                addr = `NIC_BASE_ADDR + `NIC_ISR_RAC_OFFSET;  // Clears the ISR
            end
            S_WR_DECODE: begin
                addr  = `PCIE_BASE_ADDR + `PCIE_INT_DECODE_OFFSET;
                wdata = `PCIE_INT_DECODE_CLEAR;
            end
            S_WR_FIFO: begin
                addr  = `PCIE_BASE_ADDR + `PCIE_INT_FIFO_OFFSET;
                wdata = `PCIE_INT_FIFO_CLEAR;
            end
            default: ;
        endcase
    end

    // ----------------------------------------------------------------------
    // State, request and host interrupt
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= S_IDLE;
            req     <= 1'b0;
            irq_out <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (irq_in) begin  // Level sensitive
                        req   <= 1'b1;
                        state <= S_RD_ISR;
                    end
                end
                S_PASS: begin
                    if (!irq_in) begin
                        irq_out <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: begin
                    if (!req) begin
                        req <= 1'b1;  // Re-raise after the gap cycle
                    end else if (done) begin
                        req     <= 1'b0;
                        irq_out <= (seq_next == S_PASS);
                        state   <= seq_next;
                    end
                end
            endcase
        end
    end

    // Host never sees an interrupt the NIC already withdrew
    a_no_rise_low: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(irq_out) |-> $past(irq_in));

endmodule

// File: source/desc_processor.sv
`timescale 1ns/10ps

module desc_processor (
    input  logic               clk,
    input  logic               reset_n,
    // Command FIFO
    input  logic               fifo_empty,
    input  desc_pkg::data_t    fifo_dread,
    output logic               fifo_rd_en,
    // Interrupts
    input  logic               irq_in,
    output logic               irq_out,
    // Lite bus
    output logic               lite_start,
    output desc_pkg::lite_op_t lite_op,
    output desc_pkg::addr_t    lite_addr,
    output desc_pkg::data_t    lite_wdata,
    input  logic               lite_done,
    input  desc_pkg::data_t    lite_rdata
);

    logic               irq_req;
    desc_pkg::lite_op_t irq_op;
    desc_pkg::addr_t    irq_addr;
    desc_pkg::data_t    irq_wdata;
    logic               irq_done;
    logic               tx_req;
    desc_pkg::addr_t    tx_addr;
    desc_pkg::data_t    tx_wdata;
    logic               tx_done;
    desc_pkg::data_t    rdata;  // Only the handler reads

    lite_arbiter i_arbiter (
        .clk        (clk),
        .reset_n    (reset_n),
        .irq_req    (irq_req),
        .irq_op     (irq_op),
        .irq_addr   (irq_addr),
        .irq_wdata  (irq_wdata),
        .irq_done   (irq_done),
        .tx_req     (tx_req),
        .tx_addr    (tx_addr),
        .tx_wdata   (tx_wdata),
        .tx_done    (tx_done),
        .rdata      (rdata),
        .lite_start (lite_start),
        .lite_op    (lite_op),
        .lite_addr  (lite_addr),
        .lite_wdata (lite_wdata),
        .lite_done  (lite_done),
        .lite_rdata (lite_rdata)
    );

    txcmd_forwarder i_forwarder (
        .clk        (clk),
        .reset_n    (reset_n),
        .fifo_empty (fifo_empty),
        .fifo_dread (fifo_dread),
        .fifo_rd_en (fifo_rd_en),
        .req        (tx_req),
        .addr       (tx_addr),
        .wdata      (tx_wdata),
        .done       (tx_done)
    );

    irq_handler i_irq (
        .clk     (clk),
        .reset_n (reset_n),
        .irq_in  (irq_in),
        .irq_out (irq_out),
        .req     (irq_req),
        .op      (irq_op),
        .addr    (irq_addr),
        .wdata   (irq_wdata),
        .done    (irq_done),
        .rdata   (rdata)
    );

endmodule

// File: verif/tb_lite_slave.sv
`timescale 1ns/10ps
`include "desc_config.svh"

module tb_lite_slave (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               lite_start,
    input  desc_pkg::lite_op_t lite_op,
    input  desc_pkg::addr_t    lite_addr,
    input  desc_pkg::data_t    lite_wdata,
    output logic               lite_done,
    output desc_pkg::data_t    lite_rdata
);

    localparam int MAX_LATENCY = 8;

    desc_pkg::data_t    isr_value;      // Loaded by the testbench before each interrupt
    desc_pkg::lite_op_t log_op[$];
    desc_pkg::addr_t    log_addr[$];
    desc_pkg::data_t    log_data[$];    // Write data or the data returned by a read
    int                 overlap_count;
    logic               outstanding;

    desc_pkg::lite_op_t op;
    desc_pkg::addr_t    addr;
    desc_pkg::data_t    data;
    int                 latency;

    // The read-to-clear view empties the ISR
    function automatic desc_pkg::data_t read_register(input desc_pkg::addr_t a);
        desc_pkg::data_t value;
        value = '0;
        if (a == `NIC_BASE_ADDR + `NIC_ISR_OFFSET) begin
            value = isr_value;
        end else if (a == `NIC_BASE_ADDR + `NIC_ISR_RAC_OFFSET) begin
            isr_value = '0;
        end
        return value;
    endfunction

    // ----------------------------------------------------------------------
    // Responder
    // ----------------------------------------------------------------------
    initial begin
        lite_done     = 1'b0;
        lite_rdata    = '0;
        isr_value     = '0;
        overlap_count = 0;
        outstanding   = 1'b0;
        forever begin
            @(posedge clk);
            if (reset_n === 1'b1 && lite_start === 1'b1) begin
                op      = lite_op;
                addr    = lite_addr;
                data    = lite_wdata;
                latency = $urandom_range(1, MAX_LATENCY);
                repeat (latency - 1) @(posedge clk);
                #1;
                if (op == desc_pkg::LITE_READ) begin
                    data       = read_register(addr);
                    lite_rdata = data;
                end else begin
                    lite_rdata = '0;
                    if (addr == `NIC_BASE_ADDR + `NIC_ISR_OFFSET) begin
                        isr_value = isr_value & ~data;  // Write one to clear
                    end
                end
                log_op.push_back(op);
                log_addr.push_back(addr);
                log_data.push_back(data);
                lite_done = 1'b1;
                @(posedge clk);
                #1;
                lite_done = 1'b0;
            end
        end
    end

    // Start seen while the previous access has not reported done
    always @(posedge clk) begin
        if (reset_n === 1'b1) begin
            if (lite_start === 1'b1) begin
                if (outstanding) begin
                    overlap_count++;
                end
                outstanding = 1'b1;
            end else if (lite_done === 1'b1) begin
                outstanding = 1'b0;
            end
        end
    end

endmodule

// File: verif/tb_desc_processor.sv
`timescale 1ns/10ps
`include "desc_config.svh"

module tb_desc_processor;

    localparam time CLK_PERIOD   = 8ns;
    localparam time DRIVE_DELAY  = 1ns;
    localparam int  RANDOM_SEED  = 32'h9fe1_491d;
    localparam int  CMD_PAIRS    = 30;
    localparam int  MIX_PAIRS    = 40;
    localparam int  MIX_IRQS     = 12;
    // Up to four accesses per interrupt and three directed interrupts
    localparam int  PLANNED_TXNS = CMD_PAIRS + MIX_PAIRS + 4 * (3 + MIX_IRQS);

    localparam desc_pkg::addr_t ISR_ADDR    = `NIC_BASE_ADDR + `NIC_ISR_OFFSET;
    localparam desc_pkg::addr_t RAC_ADDR    = `NIC_BASE_ADDR + `NIC_ISR_RAC_OFFSET;
    localparam desc_pkg::addr_t DECODE_ADDR = `PCIE_BASE_ADDR + `PCIE_INT_DECODE_OFFSET;
    localparam desc_pkg::addr_t FIFO_ADDR   = `PCIE_BASE_ADDR + `PCIE_INT_FIFO_OFFSET;

    typedef struct {
        desc_pkg::lite_op_t op;
        desc_pkg::addr_t    addr;
        desc_pkg::data_t    data;
    } access_t;

    logic               clk;
    logic               reset_n;
    logic               fifo_empty;
    desc_pkg::data_t    fifo_dread;
    logic               fifo_rd_en;
    logic               irq_in;
    logic               irq_out;
    logic               lite_start;
    desc_pkg::lite_op_t lite_op;
    desc_pkg::addr_t    lite_addr;
    desc_pkg::data_t    lite_wdata;
    logic               lite_done;
    desc_pkg::data_t    lite_rdata;

    desc_pkg::data_t    fifo_q[$];      // Show-ahead command FIFO
    access_t            exp_irq[$];     // Predicted interrupt side accesses
    access_t            exp_tx[$];      // Predicted forwarded writes
    int                 checked;
    logic               quiet_irq_out;  // Host interrupt must stay low
    logic               have_exp;
    access_t            exp_acc;
    access_t            got_acc;

    desc_processor i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .fifo_empty (fifo_empty),
        .fifo_dread (fifo_dread),
        .fifo_rd_en (fifo_rd_en),
        .irq_in     (irq_in),
        .irq_out    (irq_out),
        .lite_start (lite_start),
        .lite_op    (lite_op),
        .lite_addr  (lite_addr),
        .lite_wdata (lite_wdata),
        .lite_done  (lite_done),
        .lite_rdata (lite_rdata)
    );

    tb_lite_slave i_slave (
        .clk        (clk),
        .reset_n    (reset_n),
        .lite_start (lite_start),
        .lite_op    (lite_op),
        .lite_addr  (lite_addr),
        .lite_wdata (lite_wdata),
        .lite_done  (lite_done),
        .lite_rdata (lite_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(PLANNED_TXNS * 40 * CLK_PERIOD);
        abort_run("Watchdog expired before all accesses completed");
    end

    // ----------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_access(input access_t exp, input desc_pkg::lite_op_t op,
                                input desc_pkg::addr_t addr, input desc_pkg::data_t data);
        if (op !== exp.op) begin
            abort_run($sformatf("mismatch at %0t: lite_op expected %s, got %s",
                                $time, exp.op.name(), op.name()));
        end else if (addr !== exp.addr) begin
            abort_run($sformatf("mismatch at %0t: lite_addr expected %h, got %h",
                                $time, exp.addr, addr));
        end else if (data !== exp.data) begin
            abort_run($sformatf("mismatch at %0t: %s expected %h, got %h", $time,
                                (op == desc_pkg::LITE_READ) ? "lite_rdata" : "lite_wdata",
                                exp.data, data));
        end
    endtask

    task automatic check_irq(input logic expected);
        if (irq_out !== expected) begin
            abort_run($sformatf("mismatch at %0t: irq_out expected %b, got %b",
                                $time, expected, irq_out));
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s expected %b, got %b",
                                $time, name, expected, actual));
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus helpers and reference model
    // ----------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    function automatic void show_fifo_head();
        fifo_empty = (fifo_q.size() == 0);
        fifo_dread = (fifo_q.size() == 0) ? '0 : fifo_q[0];
    endfunction

    function automatic bit is_register_addr(input desc_pkg::addr_t a);
        return a == ISR_ADDR || a == RAC_ADDR || a == DECODE_ADDR || a == FIFO_ADDR;
    endfunction

    function automatic desc_pkg::addr_t random_cmd_addr();
        desc_pkg::addr_t a;
        a = $urandom;
        while (is_register_addr(a)) begin
            a = $urandom;
        end
        return a;
    endfunction

    // Kind 0 has HP_RXOK clear, 1 has it set, 2 is the clear-everything value
    function automatic desc_pkg::data_t random_isr(input int kind);
        desc_pkg::data_t v;
        v = $urandom;
        case (kind)
            0: v = v & ~`ISR_HP_RXOK;
            1: begin
                v = v | `ISR_HP_RXOK;
                if (v == `ISR_CLEAR_ALL_VALUE) begin
                    v = `ISR_HP_RXOK;
                end
            end
            default: v = `ISR_CLEAR_ALL_VALUE;
        endcase
        return v;
    endfunction

    function automatic void expect_irq(input desc_pkg::lite_op_t op,
                                       input desc_pkg::addr_t addr, input desc_pkg::data_t data);
        access_t acc;
        acc.op   = op;
        acc.addr = addr;
        acc.data = data;
        exp_irq.push_back(acc);
    endfunction

    // One command pair into the FIFO and one write expected on the bus
    function automatic void push_pair(input desc_pkg::addr_t addr, input desc_pkg::data_t data);
        access_t acc;
        acc.op   = desc_pkg::LITE_WRITE;
        acc.addr = addr;
        acc.data = data;
        fifo_q.push_back(addr);
        fifo_q.push_back(data);
        exp_tx.push_back(acc);
        show_fifo_head();
    endfunction

    task automatic run_irq(input desc_pkg::data_t isr);
        logic clear_all;
        clear_all         = (isr == `ISR_CLEAR_ALL_VALUE);
        i_slave.isr_value = isr;
        expect_irq(desc_pkg::LITE_READ, ISR_ADDR, isr);
        if (clear_all) begin
            expect_irq(desc_pkg::LITE_READ, RAC_ADDR, '0);
            expect_irq(desc_pkg::LITE_WRITE, DECODE_ADDR, `PCIE_INT_DECODE_CLEAR);
            expect_irq(desc_pkg::LITE_WRITE, FIFO_ADDR, `PCIE_INT_FIFO_CLEAR);
            quiet_irq_out = 1'b1;
        end else if ((isr & `ISR_HP_RXOK) != '0) begin
            expect_irq(desc_pkg::LITE_WRITE, ISR_ADDR, `ISR_HP_RXOK);
        end
        irq_in = 1'b1;
        if (clear_all) begin
            while (exp_irq.size() > 2) next_cycle();
            irq_in = 1'b0;  // NIC line drops once the ISR is cleared
            while (exp_irq.size() > 0) next_cycle();
            quiet_irq_out = 1'b0;
        end else begin
            while (irq_out !== 1'b1) next_cycle();
            if (exp_irq.size() != 0) begin
                abort_run("Host interrupt raised before the ISR handling finished");
            end
            irq_in = 1'b0;
            next_cycle();
            check_irq(1'b0);
        end
    endtask

    // ----------------------------------------------------------------------
    // Monitors
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (fifo_rd_en === 1'b1) begin
            if (fifo_q.size() == 0) begin
                abort_run("Command FIFO popped while empty");
            end else begin
                void'(fifo_q.pop_front());
            end
        end
        #(DRIVE_DELAY);
        show_fifo_head();
    end

    // Each logged access goes to its own predicted stream
    always @(posedge clk) begin
        while (checked < i_slave.log_addr.size()) begin
            got_acc.op   = i_slave.log_op[checked];
            got_acc.addr = i_slave.log_addr[checked];
            got_acc.data = i_slave.log_data[checked];
            have_exp     = 1'b0;
            if (is_register_addr(got_acc.addr) && exp_irq.size() != 0) begin
                exp_acc  = exp_irq.pop_front();
                have_exp = 1'b1;
            end else if (!is_register_addr(got_acc.addr) && exp_tx.size() != 0) begin
                exp_acc  = exp_tx.pop_front();
                have_exp = 1'b1;
            end
            if (!have_exp) begin
                abort_run($sformatf("Unexpected lite bus access to address %h", got_acc.addr));
            end else begin
                check_access(exp_acc, got_acc.op, got_acc.addr, got_acc.data);
                checked++;
            end
        end
        if (quiet_irq_out) begin
            check_irq(1'b0);
        end
    end

    always @(negedge clk) begin
        if (i_slave.overlap_count != 0) begin
            abort_run("Lite bus start issued while an access was still outstanding");
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(RANDOM_SEED));
        reset_n       = 1'b0;
        irq_in        = 1'b0;
        checked       = 0;
        quiet_irq_out = 1'b0;
        show_fifo_head();
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        reset_n = 1'b1;

        // Idle after reset
        repeat (20) begin
            next_cycle();
            check_level("lite_start", 1'b0, lite_start);
            check_level("fifo_rd_en", 1'b0, fifo_rd_en);
            check_irq(1'b0);
        end

        repeat (CMD_PAIRS) push_pair(random_cmd_addr(), $urandom);
        while (exp_tx.size() != 0) next_cycle();

        run_irq(random_isr(0));
        run_irq(random_isr(1));
        run_irq(random_isr(2));

        // Overlapping commands and interrupts
        fork
            repeat (MIX_PAIRS) begin
                push_pair(random_cmd_addr(), $urandom);
                repeat ($urandom_range(0, 12)) next_cycle();
            end
            repeat (MIX_IRQS) begin
                run_irq(random_isr($urandom_range(0, 2)));
                repeat ($urandom_range(0, 6)) next_cycle();
            end
        join
        while (exp_tx.size() != 0 || exp_irq.size() != 0) next_cycle();
        repeat (10) next_cycle();

        if (exp_tx.size() == 0 && exp_irq.size() == 0 && checked == i_slave.log_addr.size()) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("Predicted accesses still open at the end of the run");
        end
    end

endmodule

// File: tb.f
+incdir+source
source/desc_pkg.sv
source/lite_arbiter.sv
source/txcmd_forwarder.sv
source/irq_handler.sv
source/desc_processor.sv
verif/tb_lite_slave.sv
verif/tb_desc_processor.sv

// File: Bender.yml
package:
  name: desc_processor

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/desc_pkg.sv
      - source/lite_arbiter.sv
      - source/txcmd_forwarder.sv
      - source/irq_handler.sv
      - source/desc_processor.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_lite_slave.sv
      - verif/tb_desc_processor.sv
